// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_mem_subsystem
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

// File: logic/bus_pkg.sv
//////////////////////////////////////////////////
// memory bus types between cache and memory
// single beat request and response strobes
//////////////////////////////////////////////////
`default_nettype none

package bus_pkg;

    import core_pkg::*;

    // cycles from request strobe to response strobe
    localparam int mem_latency     = 2;
    localparam int mem_depth_words = 1024;
    localparam int mem_addr_bits   = $clog2(mem_depth_words);

    typedef logic [mem_addr_bits-1:0] mem_addr_t;

    // addr counts doublewords, not bytes
    typedef struct packed {
        logic       strobe;
        logic       we;
        dword_t     addr;
        dword_t     wdata;
        byte_strb_t wstrb;
    } mem_req_t;

    // also the write acknowledge
    typedef struct packed {
        logic   strobe;
        dword_t rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: logic/core_pkg.sv
//////////////////////////////////////////////////
// core pipeline types for the memory stage
// operation codes, stage records, cache geometry
//////////////////////////////////////////////////
`default_nettype none

package core_pkg;

    // direct mapped, one doubleword per line
    localparam int dcache_lines       = 16;
    localparam int dcache_index_bits  = 4;
    localparam int dcache_offset_bits = 3;
    localparam int dcache_tag_bits    = 64 - dcache_index_bits - dcache_offset_bits;

    typedef logic [63:0]                  dword_t;
    typedef logic [4:0]                   reg_idx_t;
    typedef logic [7:0]                   byte_strb_t;
    typedef logic [dcache_index_bits-1:0] dcache_idx_t;
    typedef logic [dcache_tag_bits-1:0]   dcache_tag_t;

    // explicit codes, golden file uses these numbers
    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_alu  = 4'd1,
        op_lb   = 4'd2,
        op_lh   = 4'd3,
        op_lw   = 4'd4,
        op_ld   = 4'd5,
        op_lbu  = 4'd6,
        op_lhu  = 4'd7,
        op_lwu  = 4'd8,
        op_sb   = 4'd9,
        op_sh   = 4'd10,
        op_sw   = 4'd11,
        op_sd   = 4'd12
    } mem_op_e;

    // record from execute
    typedef struct packed {
        logic     valid;
        dword_t   pc;
        mem_op_e  op;
        reg_idx_t rd;
        reg_idx_t rs2;
        // address for loads and stores
        dword_t   alu_result;
        dword_t   store_src;
    } ex_mem_t;

    // record to write-back
    typedef struct packed {
        logic     valid;
        dword_t   pc;
        logic     wen;
        reg_idx_t rd;
        dword_t   wdata;
    } mem_wb_t;

    typedef enum logic [1:0] {
        idle,
        lookup,
        refill,
        write_wait
    } dcache_state_e;

    function automatic logic op_is_load(mem_op_e op);
        return op inside {op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};
    endfunction

    function automatic logic op_is_store(mem_op_e op);
        return op inside {op_sb, op_sh, op_sw, op_sd};
    endfunction

endpackage

`default_nettype wire

// File: logic/dcache.sv
//////////////////////////////////////////////////
// direct mapped write-through data cache
// no write allocate, one doubleword per line,
// refill fsm toward main memory
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module dcache import core_pkg::*; import bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    // stage side
    input  logic       req_strobe,
    input  logic       req_we,
    input  dword_t     req_addr,
    input  dword_t     req_wdata,
    input  byte_strb_t req_wstrb,
    output logic       done_strobe,
    output dword_t     rdata,
    // memory side
    output mem_req_t   mem_req,
    input  mem_rsp_t   mem_rsp
);

    dcache_state_e           state;
    dcache_tag_t             tag_arr  [dcache_lines];
    dword_t                  data_arr [dcache_lines];
    logic [dcache_lines-1:0] valid_arr;

    // latched request
    dword_t      addr_q;
    dword_t      wdata_q;
    byte_strb_t  wstrb_q;

    dcache_idx_t idx;
    dcache_tag_t tag;
    logic        hit;

    assign idx = addr_q[dcache_offset_bits +: dcache_index_bits];
    assign tag = addr_q[63 -: dcache_tag_bits];
    assign hit = valid_arr[idx] && (tag_arr[idx] == tag);

    // hit answers in lookup, miss and store answer on the memory response
    assign done_strobe = ((state == lookup) && hit)
                       || (((state == refill) || (state == write_wait)) && mem_rsp.strobe);

    // refill data bypasses the array
    assign rdata = (state == refill) ? mem_rsp.rdata : data_arr[idx];

    always_ff @(posedge clk) begin
        mem_req.strobe <= 1'b0;
        case (state)
            idle: begin
                if (req_strobe) begin
                    addr_q  <= req_addr;
                    wdata_q <= req_wdata;
                    wstrb_q <= req_wstrb;
                    if (req_we) begin
                        // write-through goes out right away
                        mem_req <= '{strobe: 1'b1, we: 1'b1,
                                     addr: req_addr >> dcache_offset_bits,
                                     wdata: req_wdata, wstrb: req_wstrb};
                        state   <= write_wait;
                    end else begin
                        state <= lookup;
                    end
                end
            end
            lookup: begin
                if (hit) begin
                    state <= idle;
                end else begin
                    mem_req <= '{strobe: 1'b1, we: 1'b0,
                                 addr: addr_q >> dcache_offset_bits,
                                 wdata: '0, wstrb: '0};
                    state   <= refill;
                end
            end
            refill: begin
                if (mem_rsp.strobe) begin
                    data_arr[idx]  <= mem_rsp.rdata;
                    tag_arr[idx]   <= tag;
                    valid_arr[idx] <= 1'b1;
                    state          <= idle;
                end
            end
            write_wait: begin
                if (mem_rsp.strobe) begin
                    // merge only into a line already present
                    if (hit) begin
                        for (int i = 0; i < 8; i++) begin
                            if (wstrb_q[i]) begin
                                data_arr[idx][8*i +: 8] <= wdata_q[8*i +: 8];
                            end
                        end
                    end
                    state <= idle;
                end
            end
            default: state <= idle;
        endcase
        if (rst) begin
            state          <= idle;
            valid_arr      <= '0;
            mem_req.strobe <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/lsu_format.sv
//////////////////////////////////////////////////
// load/store data formatting
// store lane alignment with byte strobe, load
// lane select with sign or zero extension
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module lsu_format import core_pkg::*; (
    input  mem_op_e    op,
    input  dword_t     addr,
    input  dword_t     store_src,
    input  dword_t     load_raw,
    output dword_t     store_data,
    output byte_strb_t store_strb,
    output dword_t     load_value
);

    logic [2:0] offset;
    logic [5:0] shift;
    dword_t     lane;

    // byte offset inside the doubleword
    assign offset = addr[2:0];
    assign shift  = {offset, 3'b000};

    // addressed lane moved down to bit 0
    assign lane = load_raw >> shift;

    // store side
    always_comb begin
        store_data = '0;
        store_strb = '0;
        case (op)
            op_sb: begin
                store_data = {56'b0, store_src[7:0]} << shift;
                store_strb = 8'h01 << offset;
            end
            op_sh: begin
                store_data = {48'b0, store_src[15:0]} << shift;
                store_strb = 8'h03 << offset;
            end
            op_sw: begin
                store_data = {32'b0, store_src[31:0]} << shift;
                store_strb = 8'h0f << offset;
            end
            op_sd: begin
                store_data = store_src;
                store_strb = 8'hff;
            end
            // loads and non-memory ops write nothing
            default: ;
        endcase
    end

    // load side
    always_comb begin
        case (op)
            op_lb:   load_value = {{56{lane[7]}}, lane[7:0]};
            op_lh:   load_value = {{48{lane[15]}}, lane[15:0]};
            op_lw:   load_value = {{32{lane[31]}}, lane[31:0]};
            op_ld:   load_value = load_raw;
            op_lbu:  load_value = {56'b0, lane[7:0]};
            op_lhu:  load_value = {48'b0, lane[15:0]};
            op_lwu:  load_value = {32'b0, lane[31:0]};
            default: load_value = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/main_memory.sv
//////////////////////////////////////////////////
// backing memory of doublewords
// byte strobed writes, fixed latency responses,
// zero sweep after reset
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module main_memory import core_pkg::*; import bus_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    dword_t                 mem_arr [mem_depth_words];
    mem_addr_t              sweep_cnt;
    logic                   sweeping;
    mem_addr_t              word_idx;
    logic [mem_latency-1:0] strobe_sr;
    dword_t                 data_sr [mem_latency];

    assign word_idx = mem_req.addr[mem_addr_bits-1:0];

    // one word cleared per cycle until the top is reached
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_cnt <= '0;
            sweeping  <= 1'b1;
        end else if (sweeping) begin
            sweep_cnt <= sweep_cnt + 1'b1;
            if (sweep_cnt == mem_addr_t'(mem_depth_words - 1)) begin
                sweeping <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sweeping) begin
            mem_arr[sweep_cnt] <= '0;
        end else if (mem_req.strobe && mem_req.we) begin
            for (int i = 0; i < 8; i++) begin
                if (mem_req.wstrb[i]) begin
                    mem_arr[word_idx][8*i +: 8] <= mem_req.wdata[8*i +: 8];
                end
            end
        end
    end

    // response delay line, read data taken before the write lands
    always_ff @(posedge clk) begin
        strobe_sr[0] <= mem_req.strobe;
        data_sr[0]   <= mem_arr[word_idx];
        for (int i = 1; i < mem_latency; i++) begin
            strobe_sr[i] <= strobe_sr[i-1];
            data_sr[i]   <= data_sr[i-1];
        end
        if (rst) begin
            strobe_sr <= '0;
        end
    end

    assign mem_rsp = '{strobe: strobe_sr[mem_latency-1], rdata: data_sr[mem_latency-1]};

endmodule

`default_nettype wire

// File: logic/mem_stage.sv
//////////////////////////////////////////////////
// memory access pipeline stage
// holds one record, issues one cache request per
// memory op, forwards store data, builds the
// write-back record
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module mem_stage import core_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    // execute side
    input  ex_mem_t    ex_in,
    output logic       ex_ready,
    // write-back side
    output mem_wb_t    wb_out,
    input  logic       wb_ready,
    // instruction in write-back
    input  logic       fwd_wen,
    input  reg_idx_t   fwd_rd,
    input  dword_t     fwd_data,
    // cache request
    output logic       req_strobe,
    output logic       req_we,
    output dword_t     req_addr,
    output dword_t     req_wdata,
    output byte_strb_t req_wstrb,
    // cache answer
    input  logic       done_strobe,
    input  dword_t     rdata
);

    ex_mem_t cur;
    logic    issued;
    logic    done_seen;
    logic    is_load;
    logic    is_store;
    logic    is_mem;
    logic    waiting;
    logic    fwd_hit;
    dword_t  store_src;
    dword_t  load_value;
    dword_t  load_hold;

    // stage register, loads whenever ex_ready
    always_ff @(posedge clk) begin
        if (ex_ready) begin
            cur <= ex_in;
        end
        if (rst) begin
            cur.valid <= 1'b0;
        end
    end

    assign is_load  = op_is_load(cur.op);
    assign is_store = op_is_store(cur.op);
    assign is_mem   = cur.valid && (is_load || is_store);

    // memory op still waiting for the cache
    assign waiting  = is_mem && !(done_strobe || done_seen);
    assign ex_ready = waiting ? 1'b0 : wb_ready;

    // request flag and done flag, cleared when the record leaves
    always_ff @(posedge clk) begin
        if (rst) begin
            issued    <= 1'b0;
            done_seen <= 1'b0;
        end else if (ex_ready) begin
            issued    <= 1'b0;
            done_seen <= 1'b0;
        end else begin
            if (req_strobe) begin
                issued <= 1'b1;
            end
            if (done_strobe) begin
                done_seen <= 1'b1;
            end
        end
    end

    // write-back value overrides a stale rs2
    assign fwd_hit   = fwd_wen && (fwd_rd == cur.rs2) && (cur.rs2 != 5'd0);
    assign store_src = fwd_hit ? fwd_data : cur.store_src;

    lsu_format u_format (
        .op         (cur.op),
        .addr       (cur.alu_result),
        .store_src  (store_src),
        .load_raw   (rdata),
        .store_data (req_wdata),
        .store_strb (req_wstrb),
        .load_value (load_value)
    );

    // one request on the first cycle in the register
    assign req_strobe = is_mem && !issued;
    assign req_we     = is_store;
    assign req_addr   = cur.alu_result;

    // formatted load data kept across a write-back stall
    always_ff @(posedge clk) begin
        if (done_strobe) begin
            load_hold <= load_value;
        end
    end

    always_comb begin
        wb_out.valid = cur.valid && (!is_mem || done_strobe || done_seen);
        wb_out.pc    = cur.pc;
        wb_out.rd    = cur.rd;
        // x0 never written
        wb_out.wen   = (is_load || (cur.op == op_alu)) && (cur.rd != 5'd0);
        if (is_load) begin
            wb_out.wdata = done_strobe ? load_value : load_hold;
        end else if (cur.op == op_alu) begin
            wb_out.wdata = cur.alu_result;
        end else begin
            wb_out.wdata = '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/mem_subsystem.sv
//////////////////////////////////////////////////
// memory subsystem top
// chain of stage, data cache and main memory
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem import core_pkg::*; import bus_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  ex_mem_t  ex_in,
    output logic     ex_ready,
    output mem_wb_t  wb_out,
    input  logic     wb_ready,
    input  logic     fwd_wen,
    input  reg_idx_t fwd_rd,
    input  dword_t   fwd_data
);

    // stage to cache
    logic       req_strobe;
    logic       req_we;
    dword_t     req_addr;
    dword_t     req_wdata;
    byte_strb_t req_wstrb;
    logic       done_strobe;
    dword_t     rdata;

    // cache to memory
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;

    mem_stage u_stage (
        .clk         (clk),
        .rst         (rst),
        .ex_in       (ex_in),
        .ex_ready    (ex_ready),
        .wb_out      (wb_out),
        .wb_ready    (wb_ready),
        .fwd_wen     (fwd_wen),
        .fwd_rd      (fwd_rd),
        .fwd_data    (fwd_data),
        .req_strobe  (req_strobe),
        .req_we      (req_we),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_wstrb   (req_wstrb),
        .done_strobe (done_strobe),
        .rdata       (rdata)
    );

    dcache u_dcache (
        .clk         (clk),
        .rst         (rst),
        .req_strobe  (req_strobe),
        .req_we      (req_we),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_wstrb   (req_wstrb),
        .done_strobe (done_strobe),
        .rdata       (rdata),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp)
    );

    main_memory u_memory (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

`default_nettype wire

// File: testbench/golden_vectors.txt
# op addr(hex) store_src(hex) rd rs2 fwd_wen fwd_rd fwd_data(hex) exp_wen exp_wdata(hex)
# op codes: 0 none 1 alu 2 lb 3 lh 4 lw 5 ld 6 lbu 7 lhu 8 lwu 9 sb 10 sh 11 sw 12 sd
5 100 0 1 0 0 0 0 1 0
4 208 0 2 0 0 0 0 1 0
12 100 8877665544332211 0 3 0 0 0 0 0
2 107 0 4 0 0 0 0 1 ffffffffffffff88
6 107 0 5 0 0 0 0 1 88
3 106 0 6 0 0 0 0 1 ffffffffffff8877
7 106 0 7 0 0 0 0 1 8877
4 104 0 8 0 0 0 0 1 ffffffff88776655
8 104 0 9 0 0 0 0 1 88776655
4 100 0 10 0 0 0 0 1 44332211
11 300 11223344 0 12 0 0 0 0 0
9 301 aa 0 13 0 0 0 0 0
10 306 bbcc 0 14 0 0 0 0 0
5 300 0 15 0 0 0 0 1 bbcc00001122aa44
9 305 5a 0 16 0 0 0 0 0
5 300 0 17 0 0 0 0 1 bbcc5a001122aa44
12 208 1111 0 9 1 9 deadbeefcafef00d 0 0
5 208 0 18 0 0 0 0 1 deadbeefcafef00d
12 210 123456789abcdef 0 0 1 0 ffffffffffffffff 0 0
5 210 0 19 0 0 0 0 1 0123456789abcdef
1 123456789 0 20 0 0 0 0 1 123456789
0 0 0 21 0 0 0 0 0 0
2 101 0 0 0 0 0 0 0 0

// File: testbench/mem_subsystem_sva.sv
//////////////////////////////////////////////////
// handshake and strobe assertions
// bound into the memory stage
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_sva import core_pkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    wb_ready,
    input mem_wb_t wb_out,
    input logic    req_strobe,
    input logic    req_we,
    input logic    done_strobe
);

    // stalled record stays put
    assert property (@(posedge clk) disable iff (rst)
        wb_out.valid && !wb_ready |=> $stable(wb_out))
        else $error("wb_out moved while wb_ready was low");

    // write-through answered one cycle plus the memory latency later
    assert property (@(posedge clk) disable iff (rst) req_strobe && req_we |-> ##3 done_strobe)
        else $error("store request not answered three cycles after it was sent");

    // single cycle strobes
    assert property (@(posedge clk) disable iff (rst) req_strobe |=> !req_strobe)
        else $error("req_strobe longer than one cycle");
    assert property (@(posedge clk) disable iff (rst) done_strobe |=> !done_strobe)
        else $error("done_strobe longer than one cycle");

    // nothing leaves while the request is out
    assert property (@(posedge clk) disable iff (rst) req_strobe |-> !wb_out.valid)
        else $error("wb_out valid in the request cycle");

endmodule

`default_nettype wire

// File: testbench/tb_mem_subsystem.sv
//////////////////////////////////////////////////
// testbench for the memory subsystem
// golden vector stimulus, random write-back
// stalls, record and hold checks
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsystem import core_pkg::*; import bus_pkg::*; ();

    localparam int     reset_cycles = 4;
    localparam int     sweep_margin = 8;
    localparam dword_t pc_base      = 64'h0000_0000_8000_0000;
    // worst case per record is drive, 3 stall before accept, 4 miss, 3 stall and 2 margin
    localparam int     cycles_per_vector = 1 + 3 + 4 + 3 + 2;

    // one line of the golden file
    typedef struct packed {
        logic [3:0] op;
        dword_t     addr;
        dword_t     src;
        reg_idx_t   rd;
        reg_idx_t   rs2;
        logic       fwd_wen;
        reg_idx_t   fwd_rd;
        dword_t     fwd_data;
        logic       exp_wen;
        dword_t     exp_wdata;
    } vector_t;

    logic       clk = 1'b0;
    logic       rst;
    ex_mem_t    ex_in;
    logic       ex_ready;
    mem_wb_t    wb_out;
    logic       wb_ready = 1'b0;
    logic       fwd_wen;
    reg_idx_t   fwd_rd;
    dword_t     fwd_data;

    vector_t    vectors[$];
    int         errors = 0;
    int         checks = 0;
    int         consumed = 0;
    int         cycle_cnt = 0;
    int         timeout_limit = 0;
    logic [1:0] stall_left;
    logic       prev_stalled;
    mem_wb_t    prev_wb;

    always #5 clk = ~clk;

    mem_subsystem uut (
        .clk      (clk),
        .rst      (rst),
        .ex_in    (ex_in),
        .ex_ready (ex_ready),
        .wb_out   (wb_out),
        .wb_ready (wb_ready),
        .fwd_wen  (fwd_wen),
        .fwd_rd   (fwd_rd),
        .fwd_data (fwd_data)
    );

    bind mem_stage mem_subsystem_sva u_sva (
        .clk         (clk),
        .rst         (rst),
        .wb_ready    (wb_ready),
        .wb_out      (wb_out),
        .req_strobe  (req_strobe),
        .req_we      (req_we),
        .done_strobe (done_strobe)
    );

    // one ready cycle, then 0 to 3 stalled cycles
    always @(posedge clk) begin
        if (rst) begin
            wb_ready   <= 1'b1;
            stall_left <= '0;
        end else if (stall_left != 2'd0) begin
            wb_ready   <= 1'b0;
            stall_left <= stall_left - 2'd1;
        end else begin
            wb_ready   <= 1'b1;
            stall_left <= 2'($urandom % 4);
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("timeout after %0d cycles, a record never left the stage", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    // hold rule and record count sampled mid cycle
    always @(negedge clk) begin
        if (rst) begin
            prev_stalled = 1'b0;
        end else begin
            if (prev_stalled && (wb_out != prev_wb)) begin
                errors++;
                $display("FAIL at %0t: wb_out changed during a write-back stall", $time);
            end
            if (!wb_ready && ex_ready) begin
                errors++;
                $display("FAIL at %0t: ex_ready high while wb_ready low", $time);
            end
            if (wb_out.valid && wb_ready) begin
                consumed++;
            end
            prev_stalled = wb_out.valid && !wb_ready;
            prev_wb      = wb_out;
        end
    end

    task automatic read_vectors(output bit ok);
        int      fd;
        int      n;
        string   line;
        int      op_i;
        int      rd_i;
        int      rs2_i;
        int      fen_i;
        int      frd_i;
        int      wen_i;
        dword_t  addr;
        dword_t  src;
        dword_t  fdata;
        dword_t  wdata;
        vector_t v;
        ok = 1'b0;
        fd = $fopen("testbench/golden_vectors.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // comments and blank lines skipped
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %h %h %d %d %d %d %h %d %h", op_i, addr, src,
                                rd_i, rs2_i, fen_i, frd_i, fdata, wen_i, wdata);
                    if (n == 10) begin
                        v.op        = 4'(op_i);
                        v.addr      = addr;
                        v.src       = src;
                        v.rd        = 5'(rd_i);
                        v.rs2       = 5'(rs2_i);
                        v.fwd_wen   = fen_i != 0;
                        v.fwd_rd    = 5'(frd_i);
                        v.fwd_data  = fdata;
                        v.exp_wen   = wen_i != 0;
                        v.exp_wdata = wdata;
                        vectors.push_back(v);
                    end else begin
                        errors++;
                        $display("golden vector file has a malformed line: %s", line);
                    end
                end
            end
            $fclose(fd);
            ok = vectors.size() > 0;
        end
    endtask

    task automatic check_record(input int n, input dword_t pc, input vector_t v);
        checks++;
        if (wb_out.pc != pc) begin
            errors++;
            $display("FAIL at %0t: vector %0d pc %h, expected %h", $time, n, wb_out.pc, pc);
        end
        if (wb_out.wen != v.exp_wen) begin
            errors++;
            $display("FAIL at %0t: vector %0d wen %b, expected %b",
                     $time, n, wb_out.wen, v.exp_wen);
        end
        // rd and data only matter for a real write
        if (v.exp_wen && wb_out.rd != v.rd) begin
            errors++;
            $display("FAIL at %0t: vector %0d rd %0d, expected %0d", $time, n, wb_out.rd, v.rd);
        end
        if (v.exp_wen && wb_out.wdata != v.exp_wdata) begin
            errors++;
            $display("FAIL at %0t: vector %0d wdata %h, expected %h",
                     $time, n, wb_out.wdata, v.exp_wdata);
        end
    endtask

    task automatic run_vector(input int n);
        vector_t v;
        ex_mem_t rec;
        v              = vectors[n];
        rec.valid      = 1'b1;
        rec.pc         = pc_base + 64'(n * 4);
        rec.op         = mem_op_e'(v.op);
        rec.rd         = v.rd;
        rec.rs2        = v.rs2;
        rec.alu_result = v.addr;
        rec.store_src  = v.src;
        @(posedge clk);
        ex_in    <= rec;
        fwd_wen  <= v.fwd_wen;
        fwd_rd   <= v.fwd_rd;
        fwd_data <= v.fwd_data;
        // taken on the edge after ex_ready is seen high
        @(negedge clk);
        while (!ex_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        ex_in.valid <= 1'b0;
        @(negedge clk);
        while (!(wb_out.valid && wb_ready)) begin
            @(negedge clk);
        end
        check_record(n, rec.pc, v);
    endtask

    initial begin
        bit loaded;
        void'($urandom(70));
        rst      <= 1'b1;
        ex_in    <= '0;
        fwd_wen  <= 1'b0;
        fwd_rd   <= '0;
        fwd_data <= '0;
        read_vectors(loaded);
        timeout_limit = reset_cycles + mem_depth_words + 2 * sweep_margin
                      + vectors.size() * cycles_per_vector;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checks++;
        if (wb_out.valid) begin
            errors++;
            $display("FAIL at %0t: wb_out valid right after reset", $time);
        end
        // memory clears itself one word per cycle first
        repeat (mem_depth_words + sweep_margin) @(posedge clk);
        if (loaded) begin
            foreach (vectors[i]) begin
                run_vector(i);
            end
            @(posedge clk);
            @(negedge clk);
            if (consumed != vectors.size()) begin
                errors++;
                $display("write-back saw %0d records for %0d vectors", consumed, vectors.size());
            end
        end else begin
            errors++;
            $display("no vectors could be read from the golden vector file");
        end
        $display("checks: %0d  errors: %0d  records: %0d", checks, errors, consumed);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
logic/core_pkg.sv
logic/bus_pkg.sv
logic/lsu_format.sv
logic/mem_stage.sv
logic/dcache.sv
logic/main_memory.sv
logic/mem_subsystem.sv
testbench/mem_subsystem_sva.sv
testbench/tb_mem_subsystem.sv
